// ==== rtl/rv_pkg.sv ====
package rv_pkg;

	localparam int XLEN = 64;

	typedef logic [XLEN-1:0] xlen_t;	// One register or operand value
	typedef logic [4:0] reg_addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [3:0] alu_op_t;

	// Major opcodes, inst[6:0]
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;

	localparam alu_op_t ALU_ADD    = 4'd0;
	localparam alu_op_t ALU_SUB    = 4'd1;
	localparam alu_op_t ALU_SLL    = 4'd2;
	localparam alu_op_t ALU_SLT    = 4'd3;
	localparam alu_op_t ALU_SLTU   = 4'd4;
	localparam alu_op_t ALU_XOR    = 4'd5;
	localparam alu_op_t ALU_SRL    = 4'd6;
	localparam alu_op_t ALU_SRA    = 4'd7;
	localparam alu_op_t ALU_OR     = 4'd8;
	localparam alu_op_t ALU_AND    = 4'd9;
	localparam alu_op_t ALU_PASS_B = 4'd10;	// Result is src_b, used by LUI

endpackage

// ==== rtl/dec_exe_if.sv ====
interface dec_exe_if;
	import rv_pkg::*;

	logic valid;
	alu_op_t alu_op;
	xlen_t src_a;
	xlen_t src_b;
	reg_addr_t rd;
	logic wr_en;	// Low for illegal encodings

	modport dec (
		output valid,
		output alu_op,
		output src_a,
		output src_b,
		output rd,
		output wr_en
	);

	modport exe (
		input valid,
		input alu_op,
		input src_a,
		input src_b,
		input rd,
		input wr_en
	);

endinterface

// ==== rtl/reg_file.sv ====
module reg_file (
	input  logic clk,
	input  logic rst,
	input  rv_pkg::reg_addr_t rs1_addr,
	input  rv_pkg::reg_addr_t rs2_addr,
	input  logic rs1_en,
	input  logic rs2_en,
	output rv_pkg::xlen_t rs1_data,
	output rv_pkg::xlen_t rs2_data,
	input  logic wb_en,
	input  rv_pkg::reg_addr_t wb_addr,
	input  rv_pkg::xlen_t wb_data
);
	import rv_pkg::*;

	xlen_t regs [32];

	// One read port, with the pending write forwarded
	function automatic xlen_t read_port(
		input logic en,
		input reg_addr_t addr,
		input xlen_t stored,
		input logic w_en,
		input reg_addr_t w_addr,
		input xlen_t w_data
	);
		if (!en || addr == '0) begin
			return '0;
		end else if (w_en && addr == w_addr) begin
			return w_data;
		end else begin
			return stored;
		end
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && wb_addr != '0) begin	// x0 stays zero
			regs[wb_addr] <= wb_data;
		end
	end

	assign rs1_data = read_port(rs1_en, rs1_addr, regs[rs1_addr], wb_en, wb_addr, wb_data);
	assign rs2_data = read_port(rs2_en, rs2_addr, regs[rs2_addr], wb_en, wb_addr, wb_data);

endmodule

// ==== rtl/inst_decode.sv ====
module inst_decode (
	input  logic inst_valid,
	input  rv_pkg::inst_t inst,
	output rv_pkg::reg_addr_t rs1_addr,
	output rv_pkg::reg_addr_t rs2_addr,
	output logic rs1_en,
	output logic rs2_en,
	input  rv_pkg::xlen_t rs1_data,
	input  rv_pkg::xlen_t rs2_data,
	output logic illegal,
	dec_exe_if.dec dx
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_addr_t rd;
	xlen_t imm_i;
	xlen_t imm_u;
	xlen_t shamt;
	logic shift_ok;
	logic use_rs1;
	logic use_rs2;
	logic bad;

	// Maps funct3 plus the alternate bit (inst[30]) to an ALU operation
	function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
		alu_op_t op;
		case (f3)
			3'b000: op = alt ? ALU_SUB : ALU_ADD;
			3'b001: op = ALU_SLL;
			3'b010: op = ALU_SLT;
			3'b011: op = ALU_SLTU;
			3'b100: op = ALU_XOR;
			3'b101: op = alt ? ALU_SRA : ALU_SRL;
			3'b110: op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode = inst[6:0];
	assign rd = inst[11:7];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign imm_i = {{(XLEN - 12){inst[31]}}, inst[31:20]};
	assign imm_u = {{(XLEN - 32){inst[31]}}, inst[31:12], 12'b0};
	assign shamt = {{(XLEN - 6){1'b0}}, inst[25:20]};	// RV64 shift amount is six bits

	// slli and srli need zero upper bits, srai needs 010000
	assign shift_ok = (inst[31:26] == 6'b000000) ||
		(funct3 == 3'b101 && inst[31:26] == 6'b010000);

	always_comb begin
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		bad = 1'b0;
		dx.alu_op = ALU_ADD;
		dx.src_a = '0;
		dx.src_b = '0;
		case (opcode)
			OPC_OP: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				dx.alu_op = alu_sel(funct3, inst[30]);
				dx.src_a = rs1_data;
				dx.src_b = rs2_data;
				// Only sub and sra take funct7 0x20
				bad = !(funct7 == 7'h00 ||
					(funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
			end
			OPC_OP_IMM: begin
				use_rs1 = 1'b1;
				dx.src_a = rs1_data;
				if (funct3 == 3'b001 || funct3 == 3'b101) begin
					dx.alu_op = alu_sel(funct3, inst[30]);
					dx.src_b = shamt;
					bad = !shift_ok;
				end else begin
					dx.alu_op = alu_sel(funct3, 1'b0);	// Bit 30 is immediate here
					dx.src_b = imm_i;
				end
			end
			OPC_LUI: begin
				dx.alu_op = ALU_PASS_B;
				dx.src_b = imm_u;
			end
			default: begin
				bad = 1'b1;
			end
		endcase
	end

	assign rs1_addr = inst[19:15];
	assign rs2_addr = inst[24:20];
	assign rs1_en = inst_valid & use_rs1;
	assign rs2_en = inst_valid & use_rs2;

	assign illegal = inst_valid & bad;

	assign dx.valid = inst_valid;
	assign dx.rd = rd;
	assign dx.wr_en = inst_valid & ~bad;	// No write for illegal words

endmodule

// ==== rtl/exec_stage.sv ====
module exec_stage (
	input  logic clk,
	input  logic rst,
	dec_exe_if.exe dx,
	input  logic illegal_in,
	output logic wb_en,
	output rv_pkg::reg_addr_t wb_addr,
	output rv_pkg::xlen_t wb_data,
	output logic illegal
);
	import rv_pkg::*;

	xlen_t result;
	logic [5:0] shamt;
	logic lt_signed;
	logic lt_unsigned;

	assign shamt = dx.src_b[5:0];
	assign lt_signed = $signed(dx.src_a) < $signed(dx.src_b);
	assign lt_unsigned = dx.src_a < dx.src_b;

	always_comb begin
		case (dx.alu_op)
			ALU_ADD: result = dx.src_a + dx.src_b;
			ALU_SUB: result = dx.src_a - dx.src_b;
			ALU_SLL: result = dx.src_a << shamt;
			ALU_SLT: result = {{(XLEN - 1){1'b0}}, lt_signed};
			ALU_SLTU: result = {{(XLEN - 1){1'b0}}, lt_unsigned};
			ALU_XOR: result = dx.src_a ^ dx.src_b;
			ALU_SRL: result = dx.src_a >> shamt;
			ALU_SRA: result = $signed(dx.src_a) >>> shamt;
			ALU_OR: result = dx.src_a | dx.src_b;
			ALU_AND: result = dx.src_a & dx.src_b;
			ALU_PASS_B: result = dx.src_b;
			default: result = '0;
		endcase
	end

	// Control pulses, one cycle after acceptance
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_en <= 1'b0;
			illegal <= 1'b0;
		end else begin
			wb_en <= dx.valid & dx.wr_en;
			illegal <= dx.valid & illegal_in;
		end
	end

	always_ff @(posedge clk) begin
		if (dx.valid) begin
			wb_addr <= dx.rd;
			wb_data <= result;
		end
	end

endmodule

// ==== rtl/int_exec_core.sv ====
module int_exec_core (
	input  logic clk,
	input  logic rst,
	input  logic inst_valid,
	input  logic [31:0] inst,
	output logic wb_valid,
	output logic [4:0] wb_rd,
	output logic [63:0] wb_data,
	output logic illegal
);
	import rv_pkg::*;

	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	logic rs1_en;
	logic rs2_en;
	xlen_t rs1_data;
	xlen_t rs2_data;
	logic dec_illegal;

	dec_exe_if dx ();

	inst_decode i_decode (
		.inst_valid (inst_valid),
		.inst       (inst),
		.rs1_addr   (rs1_addr),
		.rs2_addr   (rs2_addr),
		.rs1_en     (rs1_en),
		.rs2_en     (rs2_en),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.illegal    (dec_illegal),
		.dx         (dx.dec)
	);

	// Write port is fed straight from the writeback registers
	reg_file i_reg_file (
		.clk      (clk),
		.rst      (rst),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_en   (rs1_en),
		.rs2_en   (rs2_en),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb_en    (wb_valid),
		.wb_addr  (wb_rd),
		.wb_data  (wb_data)
	);

	exec_stage i_exec (
		.clk        (clk),
		.rst        (rst),
		.dx         (dx.exe),
		.illegal_in (dec_illegal),
		.wb_en      (wb_valid),
		.wb_addr    (wb_rd),
		.wb_data    (wb_data),
		.illegal    (illegal)
	);

endmodule

// ==== test/tb_int_exec_core.sv ====
module tb_int_exec_core;

	localparam logic [6:0] OP_REG = 7'h33;
	localparam logic [6:0] OP_IMM = 7'h13;
	localparam logic [6:0] OP_LUI = 7'h37;

	localparam int KIND_NONE = 0;
	localparam int KIND_WRITE = 1;
	localparam int KIND_ILLEGAL = 2;

	localparam int NUM_CYCLES = 3000;
	localparam int RESET_TIMEOUT = 20;

	logic clk;
	logic rst;
	logic inst_valid;
	logic [31:0] inst;
	logic wb_valid;
	logic [4:0] wb_rd;
	logic [63:0] wb_data;
	logic illegal;

	logic [31:0] seed = 32'he6ee;
	logic [63:0] model_regs [32];
	int errors = 0;
	int checks = 0;
	int num_writes = 0;
	int num_illegal = 0;

	int_exec_core i_dut (
		.clk        (clk),
		.rst        (rst),
		.inst_valid (inst_valid),
		.inst       (inst),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data),
		.illegal    (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic roll(output logic [31:0] r);
		seed = xorshift32(seed);
		r = seed;
	endtask

	// Mostly x0 to x7, so results get reused soon
	function automatic logic [4:0] pick_reg(input logic [31:0] r);
		if (r[2:0] != 3'd0) begin
			return {2'b00, r[5:3]};
		end else begin
			return r[8:4];
		end
	endfunction

	task automatic make_inst(output logic [31:0] w);
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		int sel;
		roll(r1);
		roll(r2);
		roll(r3);
		rd = pick_reg(r2);
		rs1 = pick_reg(r2 >> 10);
		rs2 = pick_reg(r2 >> 20);
		f3 = r1[10:8];
		sel = r1 % 32'd100;
		if (sel < 40) begin
			if (r1[11] && (f3 == 3'd0 || f3 == 3'd5)) begin
				w = {7'h20, rs2, rs1, f3, rd, OP_REG};	// sub or sra
			end else begin
				w = {7'h00, rs2, rs1, f3, rd, OP_REG};
			end
		end else if (sel < 78) begin
			if (f3 == 3'd1) begin
				w = {6'b000000, r3[5:0], rs1, f3, rd, OP_IMM};
			end else if (f3 == 3'd5) begin
				w = {(r1[11] ? 6'b010000 : 6'b000000), r3[5:0], rs1, f3, rd, OP_IMM};
			end else begin
				w = {r3[11:0], rs1, f3, rd, OP_IMM};
			end
		end else if (sel < 90) begin
			w = {r3[19:0], rd, OP_LUI};
		end else begin
			case (r1[13:12])
				2'd0: w = {r3[31:7], 7'h03};	// Load, not supported
				2'd1: w = {r3[6:0] | 7'h01, rs2, rs1, f3, rd, OP_REG};
				2'd2: w = {r3[31:26] | 6'b100000, r3[5:0], rs1,
					(r1[14] ? 3'b001 : 3'b101), rd, OP_IMM};
				default: w = r3;	// May happen to be legal
			endcase
		end
	endtask

	function automatic logic [63:0] alu(input logic [2:0] f3, input logic alt,
		input logic [63:0] a, input logic [63:0] b);
		case (f3)
			3'd0: begin
				if (alt) begin
					return a - b;
				end
				return a + b;
			end
			3'd1: return a << b[5:0];
			3'd2: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			3'd3: return (a < b) ? 64'd1 : 64'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt) begin
					return $signed(a) >>> b[5:0];
				end
				return a >> b[5:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// Decodes one accepted word and updates the model registers at once
	task automatic model_exec(input logic [31:0] w, output int kind,
		output logic [4:0] rd, output logic [63:0] data);
		logic [2:0] f3;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] imm;
		logic ok;
		f3 = w[14:12];
		rd = w[11:7];
		a = model_regs[w[19:15]];
		b = model_regs[w[24:20]];
		imm = {{52{w[31]}}, w[31:20]};
		ok = 1'b0;
		data = '0;
		case (w[6:0])
			OP_REG: begin
				ok = (w[31:25] == 7'h00) ||
					(w[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
				data = alu(f3, w[30], a, b);
			end
			OP_IMM: begin
				if (f3 == 3'd1) begin
					ok = (w[31:26] == 6'b000000);
					data = alu(f3, 1'b0, a, {58'b0, w[25:20]});
				end else if (f3 == 3'd5) begin
					ok = (w[31:26] == 6'b000000) || (w[31:26] == 6'b010000);
					data = alu(f3, w[30], a, {58'b0, w[25:20]});
				end else begin
					ok = 1'b1;
					data = alu(f3, 1'b0, a, imm);
				end
			end
			OP_LUI: begin
				ok = 1'b1;
				data = {{32{w[31]}}, w[31:12], 12'h000};
			end
			default: ok = 1'b0;
		endcase
		if (ok) begin
			kind = KIND_WRITE;
			if (rd != 5'd0) begin
				model_regs[rd] = data;	// x0 stays zero in the model too
			end
		end else begin
			kind = KIND_ILLEGAL;
		end
	endtask

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	initial begin
		int wait_cycles;
		int exp_kind;
		logic [4:0] exp_rd;
		logic [63:0] exp_data;
		logic [31:0] r;
		logic [31:0] w;
		rst <= 1'b1;
		inst_valid <= 1'b0;
		inst <= '0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		wait_cycles = 0;
		while ((wb_valid !== 1'b0 || illegal !== 1'b0) && wait_cycles < RESET_TIMEOUT) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (wb_valid !== 1'b0 || illegal !== 1'b0) begin
			$display("wb_valid or illegal was not low %0d cycles after reset", RESET_TIMEOUT);
			$display("Simulation failed");
			$finish;
		end else begin
			for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
				exp_kind = KIND_NONE;	// Word driven last edge is taken here
				exp_rd = '0;
				exp_data = '0;
				if (inst_valid) begin
					model_exec(inst, exp_kind, exp_rd, exp_data);
				end
				roll(r);
				if (cycle >= 4 && r % 32'd10 < 32'd8) begin	// Idle first, then 80% issue
					make_inst(w);
					inst_valid <= 1'b1;
					inst <= w;
				end else begin
					inst_valid <= 1'b0;
					inst <= r;	// Junk word, must be ignored
				end
				@(negedge clk);
				if (exp_kind == KIND_WRITE) begin
					num_writes++;
					compare("wb_valid", {63'b0, wb_valid}, 64'd1);
					compare("illegal", {63'b0, illegal}, 64'd0);
					compare("wb_rd", {59'b0, wb_rd}, {59'b0, exp_rd});
					compare("wb_data", wb_data, exp_data);
				end else if (exp_kind == KIND_ILLEGAL) begin
					num_illegal++;
					compare("wb_valid", {63'b0, wb_valid}, 64'd0);
					compare("illegal", {63'b0, illegal}, 64'd1);
				end else begin
					compare("wb_valid", {63'b0, wb_valid}, 64'd0);
					compare("illegal", {63'b0, illegal}, 64'd0);
				end
				@(posedge clk);
			end
			$display("Writes %0d, illegal %0d, checks %0d, errors %0d",
				num_writes, num_illegal, checks, errors);
			if (errors == 0) begin
				$display("Simulation passed");
			end else begin
				$display("Simulation failed");
			end
			$finish;
		end
	end

endmodule

// ==== int_exec_core.f ====
rtl/rv_pkg.sv
rtl/dec_exe_if.sv
rtl/reg_file.sv
rtl/inst_decode.sv
rtl/exec_stage.sv
rtl/int_exec_core.sv
test/tb_int_exec_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_int_exec_core
FILELIST  = int_exec_core.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Test passed"; \
	else \
		echo "Test failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
